/* vlog.f */
+incdir+tests
hw/zx_pkg.sv
hw/zbus_ctrl.sv
hw/zport_regs.sv
hw/atm_pager.sv
hw/mem_xlat.sv
hw/dos_trap.sv
hw/zx_mem_top.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: zx_mem

sources:
  - files:
      - hw/zx_pkg.sv
      - hw/zbus_ctrl.sv
      - hw/zport_regs.sv
      - hw/atm_pager.sv
      - hw/mem_xlat.sv
      - hw/dos_trap.sv
      - hw/zx_mem_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_top.sv

/* tests/tb_tasks.svh */
/*
 * Bus access tasks, value check and directed tests, included in tb_top.
 */

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp)
	begin
		$display("Fail %s: got %h, expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic abort_timeout(input string what);
	$display("Timeout: %s did not come within %0d cycles", what, TMO);
	errors++;
	finish_run();
endtask

task automatic report_test(input string name, input int start);
	if (errors == start)
		$display("test %s: ok", name);
	else
		$display("test %s: %0d errors", name, errors - start);
endtask

// model read data is the low address byte xor the top byte
function automatic logic [7:0] model_byte(input logic [PHYS_AW-1:0] pa);
	return pa[7:0] ^ pa[PHYS_AW-1:PHYS_AW-8];
endfunction

function automatic logic [PHYS_AW-1:0] phys(input logic [6:0] pg, input logic [15:0] a);
	return {pg, a[13:0]};
endfunction

////////////////////////////////////////////////////////////////////////////
// bus access
////////////////////////////////////////////////////////////////////////////
task automatic send_req(input logic [15:0] addr, input logic [7:0] data,
		input logic wr, input logic io, input logic m1);
	int t;
	req_addr  = addr;
	req_wdata = data;
	req_write = wr;
	req_io    = io;
	req_m1    = m1;
	req_valid = 1'b1;
	t = 0;
	while (!req_ready && t < TMO)
	begin
		@(posedge fclk);
		#1;
		t++;
	end
	if (!req_ready)
		abort_timeout("req_ready");
	// acceptance edge
	@(posedge fclk);
	#1;
	req_valid = 1'b0;
	req_m1    = 1'b0;
endtask

task automatic get_rsp(input int stall, output logic [7:0] data);
	int t;
	t = 0;
	while (!rsp_valid && t < TMO)
	begin
		@(posedge fclk);
		#1;
		t++;
	end
	if (!rsp_valid)
		abort_timeout("rsp_valid");
	// hold the response back for a while
	repeat (stall)
	begin
		@(posedge fclk);
		#1;
	end
	data = rsp_rdata;
	rsp_ready = 1'b1;
	@(posedge fclk);
	#1;
	rsp_ready = 1'b0;
endtask

task automatic io_access(input logic [15:0] port, input logic wr, input logic [7:0] data,
		output logic [7:0] rd);
	send_req(port, data, wr, 1'b1, 1'b0);
	// I/O answers one cycle after acceptance
	check("rsp_valid", rsp_valid, 1);
	get_rsp(0, rd);
endtask

task automatic mem_access(input logic [15:0] addr, input logic wr, input logic m1,
		input logic [7:0] data, input int stall, output logic [7:0] rd);
	int n;
	n = xfer_cnt;
	send_req(addr, data, wr, 1'b0, m1);
	get_rsp(stall, rd);
	got_xfer = (xfer_cnt != n);
endtask

task automatic check_read(input logic [15:0] addr, input logic m1,
		input logic [PHYS_AW-1:0] pa, input logic rom);
	logic [7:0] rd;
	mem_access(addr, 1'b0, m1, 8'h00, 0, rd);
	check("mem handshake", got_xfer, 1);
	check("mem_addr", xfer_addr, pa);
	check("mem_rom", xfer_rom, rom);
	check("rsp_rdata", rd, model_byte(pa));
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////
task automatic reset_defaults();
	check("req_ready", req_ready, 1);
	check("rsp_valid", rsp_valid, 0);
	check("mem_valid", mem_valid, 0);
	check("border", border, 0);
	check("beep", beep, 0);
	check("dos", dos, 0);
	check_read(16'h0000, 1'b0, phys(7'd2, 16'h0000), 1'b1);
endtask

task automatic port_regs();
	logic [7:0] rd;
	io_access(16'h00FE, 1'b1, 8'h15, rd);
	check("border", border, 3'd5);
	check("beep", beep, 1);
	io_access(16'h7FFD, 1'b1, 8'h06, rd);
	check_read(16'hC123, 1'b0, phys(7'd6, 16'hC123), 1'b0);
	check_read(16'h4001, 1'b0, phys(7'd5, 16'h4001), 1'b0);
	// bank 3, 48K rom and lock, then a write that must be ignored
	io_access(16'h7FFD, 1'b1, 8'h33, rd);
	io_access(16'h7FFD, 1'b1, 8'h07, rd);
	check_read(16'hC000, 1'b0, phys(7'd3, 16'hC000), 1'b0);
	check_read(16'h0000, 1'b0, phys(7'd3, 16'h0000), 1'b1);
endtask

task automatic trap_dos();
	check_read(16'h3D00, 1'b1, phys(7'd3, 16'h3D00), 1'b1);
	check("dos", dos, 1);
	check_read(16'h0000, 1'b0, phys(7'd1, 16'h0000), 1'b1);
	check_read(16'h8000, 1'b1, phys(7'd2, 16'h8000), 1'b0);
	check("dos", dos, 0);
endtask

task automatic atm_paging();
	logic [7:0] rd;
	io_access(16'h0077, 1'b1, 8'h10, rd);
	io_access(16'h00F7, 1'b1, 8'h85, rd);
	io_access(16'h40F7, 1'b1, 8'h03, rd);
	io_access(16'h80F7, 1'b1, 8'h24, rd);
	io_access(16'hC0F7, 1'b1, 8'hFF, rd);
	check_read(16'h0123, 1'b0, phys(7'h05, 16'h0123), 1'b0);
	check_read(16'h4567, 1'b0, phys(7'h03, 16'h4567), 1'b1);
	// dos_bank with dos off turns rom page 4 into 6
	check_read(16'h89AB, 1'b0, phys(7'h06, 16'h89AB), 1'b1);
	check_read(16'hCDEF, 1'b0, phys(7'h7F, 16'hCDEF), 1'b0);
	io_access(16'h00BE, 1'b0, 8'h00, rd);
	check("rsp_rdata", rd, 8'h7A);
	io_access(16'h02BE, 1'b0, 8'h00, rd);
	check("rsp_rdata", rd, 8'hDB);
	io_access(16'h0055, 1'b0, 8'h00, rd);
	check("rsp_rdata", rd, 8'hFF);
endtask

task automatic write_protect();
	logic [7:0]         rd;
	logic [15:0]        a;
	logic [PHYS_AW-1:0] pa;
	// window 3 protected, window 1 still holds rom
	io_access(16'h0077, 1'b1, 8'h18, rd);
	mem_access(16'hC010, 1'b1, 1'b0, 8'h5A, 0, rd);
	check("mem handshake", got_xfer, 0);
	mem_access(16'h4010, 1'b1, 1'b0, 8'h5A, 0, rd);
	check("mem handshake", got_xfer, 0);
	mem_access(16'h0010, 1'b1, 1'b0, 8'hA5, 1, rd);
	check("mem handshake", got_xfer, 1);
	check("mem_write", xfer_write, 1);
	check("mem_wdata", xfer_wdata, 8'hA5);
	check("mem_addr", xfer_addr, phys(7'h05, 16'h0010));
	for (int i = 0; i < 8; i++)
	begin
		a  = i[0] ? (16'hC000 | 16'(i << 4)) : 16'(i * 257);
		pa = phys(i[0] ? 7'h7F : 7'h05, a);
		mem_access(a, 1'b0, 1'b0, 8'h00, i % 3, rd);
		check("mem_addr", xfer_addr, pa);
		check("rsp_rdata", rd, model_byte(pa));
	end
endtask

/* tests/tb_top.sv */
/*
 * Testbench for the paging core: clock, reset, DUT, a memory responder with
 * random ready delays, and the directed test sequence from tb_tasks.svh.
 */

`timescale 1ns/1ps

module tb_top import zx_pkg::*; ();

	localparam int TMO = 64;

	logic               fclk;
	logic               rst_n;
	logic               req_valid, req_ready, req_write, req_io, req_m1;
	logic [15:0]        req_addr;
	logic [7:0]         req_wdata;
	logic               rsp_valid, rsp_ready;
	logic [7:0]         rsp_rdata;
	logic               mem_valid, mem_ready, mem_rom, mem_write;
	logic [PHYS_AW-1:0] mem_addr;
	logic [7:0]         mem_wdata, mem_rdata;
	logic [2:0]         border;
	logic               beep, dos;

	// memory model state and the last recorded transfer
	integer             seed;
	int                 mem_wait;
	int                 xfer_cnt;
	logic [PHYS_AW-1:0] xfer_addr;
	logic               xfer_rom, xfer_write, got_xfer;
	logic [7:0]         xfer_wdata;
	int                 errors, checks, err_start;

	zx_mem_top #(.DOS_TRAP_HI(8'h3D)) dut_i (.*);

	initial
	begin
		fclk = 1'b0;
		forever
			#4 fclk = ~fclk;
	end

	`include "tb_tasks.svh"

	////////////////////////////////////////////////////////////////////////////
	// memory responder
	////////////////////////////////////////////////////////////////////////////
	always @(posedge fclk)
	begin
		#1;
		mem_ready = 1'b0;
		if (mem_valid && mem_wait > 0)
			mem_wait--;
		else if (mem_valid)
		begin
			// transfer happens at the next edge
			mem_ready  = 1'b1;
			mem_rdata  = model_byte(mem_addr);
			xfer_addr  = mem_addr;
			xfer_rom   = mem_rom;
			xfer_write = mem_write;
			xfer_wdata = mem_wdata;
			xfer_cnt++;
			mem_wait   = $unsigned($random(seed)) % 4;
		end
	end

	task automatic finish_run();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	initial
	begin
		seed      = 32'h40eb;
		mem_wait  = 0;
		xfer_cnt  = 0;
		mem_ready = 1'b0;
		mem_rdata = 8'h00;
		errors    = 0;
		checks    = 0;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_addr  = 16'h0000;
		req_wdata = 8'h00;
		req_write = 1'b0;
		req_io    = 1'b0;
		req_m1    = 1'b0;
		rsp_ready = 1'b0;
		repeat (8)
			@(posedge fclk);
		#1;
		rst_n = 1'b1;
		err_start = errors;
		reset_defaults();
		report_test("reset defaults", err_start);
		err_start = errors;
		port_regs();
		report_test("port FE and 7FFD", err_start);
		err_start = errors;
		trap_dos();
		report_test("DOS trap", err_start);
		err_start = errors;
		atm_paging();
		report_test("ATM paging and readback", err_start);
		err_start = errors;
		write_protect();
		report_test("write protection and back-pressure", err_start);
		finish_run();
	end

endmodule

/* hw/zx_mem_top.sv */
/*
 * Top of the Z80 paging core. Connects the bus FSM, port registers, ATM
 * pager, address translator and DOS trap.
 */

`timescale 1ns/1ps

module zx_mem_top import zx_pkg::*; #(
	parameter logic [7:0] DOS_TRAP_HI = 8'h3D
) (
	input  logic               fclk,
	input  logic               rst_n,
	// cpu requests
	input  logic               req_valid,
	output logic               req_ready,
	input  logic [15:0]        req_addr,
	input  logic [7:0]         req_wdata,
	input  logic               req_write,
	input  logic               req_io,
	input  logic               req_m1,
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output logic [7:0]         rsp_rdata,
	// physical memory
	output logic               mem_valid,
	input  logic               mem_ready,
	output logic [PHYS_AW-1:0] mem_addr,
	output logic               mem_rom,
	output logic               mem_write,
	output logic [7:0]         mem_wdata,
	input  logic [7:0]         mem_rdata,
	// status
	output logic [2:0]         border,
	output logic               beep,
	output logic               dos
);

	pg_word_t [WIN_N-1:0]     page_words;
	logic [WIN_N-1:0]         wrdis_mask;
	logic                     pager_en;
	logic [PHYS_AW-1:0]       xl_addr;
	logic                     xl_rom;
	logic                     xl_wrdis;
	logic [15:0]              cur_addr;
	logic                     wr_7ffd;
	logic                     wr_fe;
	logic                     wr_page;
	logic                     wr_ctrl;
	logic [$clog2(WIN_N)-1:0] win_sel;
	logic [7:0]               wdata;
	logic                     fetch;
	logic [2:0]               ram_bank;
	logic                     rom_sel;

	zbus_ctrl bus_i (
		.fclk(fclk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_write(req_write), .req_io(req_io), .req_m1(req_m1),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
		.mem_rom(mem_rom), .mem_write(mem_write), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .page_words(page_words),
		.xl_addr(xl_addr), .xl_rom(xl_rom), .xl_wrdis(xl_wrdis), .cur_addr(cur_addr),
		.wr_7ffd(wr_7ffd), .wr_fe(wr_fe), .wr_page(wr_page), .wr_ctrl(wr_ctrl),
		.win_sel(win_sel), .wdata(wdata), .fetch(fetch)
	);

	zport_regs ports_i (
		.fclk(fclk), .rst_n(rst_n), .wr_7ffd(wr_7ffd), .wr_fe(wr_fe), .wdata(wdata),
		.ram_bank(ram_bank), .rom_sel(rom_sel), .border(border), .beep(beep)
	);

	atm_pager pager_i (
		.fclk(fclk), .rst_n(rst_n), .wr_page(wr_page), .wr_ctrl(wr_ctrl),
		.win_sel(win_sel), .wdata(wdata), .page_words(page_words),
		.wrdis_mask(wrdis_mask), .pager_en(pager_en)
	);

	mem_xlat xlat_i (
		.cur_addr(cur_addr), .page_words(page_words), .wrdis_mask(wrdis_mask),
		.pager_en(pager_en), .ram_bank(ram_bank), .rom_sel(rom_sel), .dos(dos),
		.xl_addr(xl_addr), .xl_rom(xl_rom), .xl_wrdis(xl_wrdis)
	);

	dos_trap #(
		.DOS_TRAP_HI(DOS_TRAP_HI)
	) dos_i (
		.fclk(fclk), .rst_n(rst_n), .fetch(fetch), .cur_addr(cur_addr),
		.xl_rom(xl_rom), .rom_sel(rom_sel), .dos(dos)
	);

endmodule

/* hw/dos_trap.sv */
/*
 * DOS ROM signal, switched by M1 fetches: on at the trap page inside the
 * BASIC48 ROM, off at any fetch from RAM.
 */

`timescale 1ns/1ps

module dos_trap #(
	parameter logic [7:0] DOS_TRAP_HI = 8'h3D
) (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        fetch,
	input  logic [15:0] cur_addr,
	input  logic        xl_rom,
	input  logic        rom_sel,
	output logic        dos
);

	logic trap_hit;

	// trap page only counts in the 48K ROM
	assign trap_hit = (cur_addr[15:8] == DOS_TRAP_HI) && xl_rom && rom_sel;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (fetch)
		begin
			if (trap_hit)
				dos <= 1'b1;
			else if (!xl_rom)
				dos <= 1'b0;
		end
	end

endmodule

/* hw/mem_xlat.sv */
/*
 * Combinational address translation: picks the window from a[15:14] and
 * builds the physical ROM or RAM address in Pentagon or ATM mode.
 */

`timescale 1ns/1ps

module mem_xlat import zx_pkg::*; (
	input  logic [15:0]          cur_addr,
	input  pg_word_t [WIN_N-1:0] page_words,
	input  logic [WIN_N-1:0]     wrdis_mask,
	input  logic                 pager_en,
	input  logic [2:0]           ram_bank,
	input  logic                 rom_sel,
	input  logic                 dos,
	output logic [PHYS_AW-1:0]   xl_addr,
	output logic                 xl_rom,
	output logic                 xl_wrdis
);

	logic [$clog2(WIN_N)-1:0] win;
	pg_word_t                 pw;
	logic [ROM_PG_W-1:0]      rom_pg;
	logic [RAM_PG_W-1:0]      pg;

	assign win = cur_addr[15:14];
	assign pw  = page_words[win];

	always_comb
	begin
		rom_pg = '0;
		pg     = '0;
		xl_rom = 1'b0;
		if (!pager_en)
		begin
			// pentagon map: rom, 5, 2, bank
			case (win)
				2'd0:
				begin
					xl_rom = 1'b1;
					rom_pg = {{(ROM_PG_W-2){1'b0}}, ~dos, rom_sel};
				end
				2'd1: pg = RAM_PG_W'(5);
				2'd2: pg = RAM_PG_W'(2);
				default: pg = {{(RAM_PG_W-3){1'b0}}, ram_bank};
			endcase
		end
		else if (pw.ram.sel_ram)
			pg = pw.ram.ram_pg;
		else
		begin
			xl_rom = 1'b1;
			rom_pg = pw.rom.rom_pg;
			if (pw.rom.dos_bank)
				rom_pg[1] = ~dos;
		end
		if (xl_rom)
			pg = {{(RAM_PG_W-ROM_PG_W){1'b0}}, rom_pg};
	end

	assign xl_addr  = {pg, cur_addr[WIN_AW-1:0]};
	assign xl_wrdis = wrdis_mask[win] | xl_rom;

endmodule

/* hw/atm_pager.sv */
/*
 * ATM pager state: one page word per 16 KB window from port F7, plus the
 * write-protect mask and pager enable from port 77.
 */

`timescale 1ns/1ps

module atm_pager import zx_pkg::*; (
	input  logic                     fclk,
	input  logic                     rst_n,
	input  logic                     wr_page,
	input  logic                     wr_ctrl,
	input  logic [$clog2(WIN_N)-1:0] win_sel,
	input  logic [7:0]               wdata,
	output pg_word_t [WIN_N-1:0]     page_words,
	output logic [WIN_N-1:0]         wrdis_mask,
	output logic                     pager_en
);

	////////////////////////////////////////////////////////////////////////////
	// page words
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			page_words <= '0;
		else if (wr_page)
			page_words[win_sel] <= pg_word_t'(wdata);
	end

	// control port
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			wrdis_mask <= '0;
			pager_en   <= 1'b0;
		end
		else if (wr_ctrl)
		begin
			wrdis_mask <= wdata[WIN_N-1:0];
			pager_en   <= wdata[4];
		end
	end

	// both strobes come from one port decode
	a_one_strobe: assert property (@(posedge fclk) disable iff (!rst_n)
		!(wr_page && wr_ctrl));

endmodule

/* hw/zport_regs.sv */
/*
 * Pentagon 7FFD paging register with its lock bit, and the FE border/beeper
 * register. Written by strobes from the bus controller.
 */

`timescale 1ns/1ps

module zport_regs (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       wr_7ffd,
	input  logic       wr_fe,
	input  logic [7:0] wdata,
	output logic [2:0] ram_bank,
	output logic       rom_sel,
	output logic [2:0] border,
	output logic       beep
);

	// bits 2..0 bank, 3 screen, 4 rom, 5 lock
	logic [5:0] p7ffd;
	logic       locked;

	assign locked   = p7ffd[5];
	assign ram_bank = p7ffd[2:0];
	assign rom_sel  = p7ffd[4];

	////////////////////////////////////////////////////////////////////////////
	// 7FFD
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			p7ffd <= 6'd0;
		else if (wr_7ffd && !locked)
			p7ffd <= wdata[5:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// FE
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			border <= 3'd0;
			beep   <= 1'b0;
		end
		else if (wr_fe)
		begin
			border <= wdata[2:0];
			// tape out bit 3 is not used here
			beep   <= wdata[4];
		end
	end

endmodule

/* hw/zbus_ctrl.sv */
/*
 * CPU bus control FSM: accepts requests, decodes port writes into strobes,
 * runs the memory handshake and returns one response per request.
 */

`timescale 1ns/1ps

module zbus_ctrl import zx_pkg::*; (
	input  logic                       fclk,
	input  logic                       rst_n,
	input  logic                       req_valid,
	output logic                       req_ready,
	input  logic [15:0]                req_addr,
	input  logic [7:0]                 req_wdata,
	input  logic                       req_write,
	input  logic                       req_io,
	input  logic                       req_m1,
	output logic                       rsp_valid,
	input  logic                       rsp_ready,
	output logic [7:0]                 rsp_rdata,
	output logic                       mem_valid,
	input  logic                       mem_ready,
	output logic [PHYS_AW-1:0]         mem_addr,
	output logic                       mem_rom,
	output logic                       mem_write,
	output logic [7:0]                 mem_wdata,
	input  logic [7:0]                 mem_rdata,
	input  pg_word_t [WIN_N-1:0]       page_words,
	input  logic [PHYS_AW-1:0]         xl_addr,
	input  logic                       xl_rom,
	input  logic                       xl_wrdis,
	output logic [15:0]                cur_addr,
	output logic                       wr_7ffd,
	output logic                       wr_fe,
	output logic                       wr_page,
	output logic                       wr_ctrl,
	output logic [$clog2(WIN_N)-1:0]   win_sel,
	output logic [7:0]                 wdata,
	output logic                       fetch
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_MEM  = 2'd1;
	localparam logic [1:0] S_RSP  = 2'd2;

	logic [1:0]  state;
	logic [15:0] addr_q;
	logic        accept;
	logic        io_wr;
	logic [7:0]  io_rdata;

	assign req_ready = (state == S_IDLE);
	assign mem_valid = (state == S_MEM);
	assign rsp_valid = (state == S_RSP);

	assign accept = req_valid && req_ready;
	assign io_wr  = accept && req_io && req_write;

	// translate the live request while idle, the held one afterwards
	assign cur_addr = req_ready ? req_addr : addr_q;

	////////////////////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////////////////////
	assign wr_7ffd = io_wr && !req_addr[15] && !req_addr[1];
	assign wr_fe   = io_wr && (req_addr[7:0] == PORT_BORDER);
	assign wr_page = io_wr && (req_addr[7:0] == PORT_ATM_PAGE);
	assign wr_ctrl = io_wr && (req_addr[7:0] == PORT_ATM_CTRL);
	assign win_sel = req_addr[15:14];
	assign wdata   = req_wdata;
	assign fetch   = accept && !req_io && req_m1;

	// BE readback is inverted, a[9:8] picks the window
	always_comb
	begin
		if (req_addr[7:0] == PORT_PAGE_RB)
			io_rdata = ~page_words[req_addr[9:8]];
		else
			io_rdata = 8'hFF;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			state <= S_IDLE;
		else
		begin
			case (state)
				S_IDLE:
					if (req_valid)
					begin
						// protected writes skip the memory side
						if (req_io || (req_write && xl_wrdis))
							state <= S_RSP;
						else
							state <= S_MEM;
					end
				S_MEM:
					if (mem_ready)
						state <= S_RSP;
				S_RSP:
					if (rsp_ready)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// request payload, captured at acceptance
	always_ff @(posedge fclk)
	begin
		if (accept)
		begin
			addr_q    <= req_addr;
			mem_addr  <= xl_addr;
			mem_rom   <= xl_rom;
			mem_write <= req_write;
			mem_wdata <= req_wdata;
		end
		if (accept && req_io)
			rsp_rdata <= io_rdata;
		else if (mem_valid && mem_ready)
			rsp_rdata <= mem_rdata;
	end

	a_rsp_hold: assert property (@(posedge fclk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

	// write protect comes from the translator
	a_no_prot_wr: assert property (@(posedge fclk) disable iff (!rst_n)
		$rose(mem_valid) |-> !(mem_write && xl_wrdis));

endmodule

/* hw/zx_pkg.sv */
/*
 * Shared widths, I/O port numbers and the ATM page word for the paging core.
 * Imported by every RTL block that needs them.
 */

package zx_pkg;

	// memory windows and address widths
	localparam int WIN_N    = 4;
	localparam int WIN_AW   = 14;
	localparam int PHYS_AW  = 21;
	localparam int RAM_PG_W = 7;
	localparam int ROM_PG_W = 5;

	// low byte of decoded I/O ports
	localparam logic [7:0] PORT_ATM_PAGE = 8'hF7;
	localparam logic [7:0] PORT_ATM_CTRL = 8'h77;
	localparam logic [7:0] PORT_PAGE_RB  = 8'hBE;
	localparam logic [7:0] PORT_BORDER   = 8'hFE;

	////////////////////////////////////////////////////////////////////////////
	// ATM window page word
	// top bit selects how the rest of the byte is read
	////////////////////////////////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic                sel_ram;
			logic [RAM_PG_W-1:0] ram_pg;
		} ram;
		struct packed {
			logic                sel_ram;
			logic                spare;
			// page bit 1 follows the DOS signal
			logic                dos_bank;
			logic [ROM_PG_W-1:0] rom_pg;
		} rom;
	} pg_word_t;

endpackage
